//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       := tb_zsp_compact
FILELIST  := files.f
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- files.f
zsp_pkg.sv
zsp_compacter.sv
zsp_line_fifo.sv
zsp_migrator.sv
zsp_list_table.sv
zsp_compact_top.sv
tb_zsp_mem.sv
tb_zsp_compact.sv

//--- tb_zsp_compact.sv
`timescale 1ns/1ps

module tb_zsp_compact import zsp_pkg::*; ();

	localparam logic [WAY_W-1:0]  WAY_A    = 20'h00010; // head
	localparam logic [WAY_W-1:0]  WAY_B    = 20'h00020;
	localparam logic [WAY_W-1:0]  WAY_C    = 20'h00030; // tail
	localparam logic [3:0]        SIZE     = 4'd3;
	localparam logic [ADDR_W-1:0] SRC_BASE = 32'h0003_0400; // page0 of way C
	localparam logic [ADDR_W-1:0] DST_BASE = 32'h0001_0800; // free page1 of way A
	localparam int                LIMIT    = 2000;

	logic             clk_i, rst_ni, compact_trig, tbl_load, arready, wready, err_req;
	logic [WAY_W-1:0] load_head, load_tail, list_head, list_tail;
	logic             compact_done, bus_error, meta_pend;
	logic [7:0]       freed_ways;
	rd_req_t          rd_req;
	rd_resp_t         rd_resp;
	wr_req_t          wr_req;
	int               errors, tests, rd_cnt, wr_cnt, done_cnt, start, rd0, wr0, done0;

	zsp_compact_top dut_i (
		.clk_i, .rst_ni, .compact_trig, .tbl_load, .load_head, .load_tail, .rd_req, .arready,
		.rd_resp, .wr_req, .wready, .compact_done, .bus_error, .list_head, .list_tail,
		.freed_ways
	);

	tb_zsp_mem #(.WAY_A(WAY_A), .WAY_B(WAY_B), .WAY_C(WAY_C), .SIZE(SIZE)) mem_i (
		.clk_i, .rst_ni, .rd_req, .err_req, .arready, .wready, .rd_resp
	);

	always #50 clk_i = ~clk_i;

	function automatic logic [DATA_W-1:0] line_word(input logic [ADDR_W-1:0] a);
		return {a * 32'h9e37_79b9, a ^ 32'hc3c3_3c3c};
	endfunction

	function automatic logic is_meta(input logic [ADDR_W-1:0] a);
		return a >= LIST_BASE || a[11:0] == 12'h000;
	endfunction

	always @(posedge clk_i) begin
		rd_cnt   <= rd_cnt + int'(rd_req.arvalid);
		wr_cnt   <= wr_cnt + int'(wr_req.wvalid);
		done_cnt <= done_cnt + int'(compact_done);
		if (!rst_ni)
			meta_pend <= 1'b0;
		else if (rd_req.arvalid && is_meta(rd_req.addr))
			meta_pend <= 1'b1;
		else if (rd_resp.rvalid)
			meta_pend <= 1'b0;
	end

	a_wr_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wr_req.wvalid |-> wr_req.wdata == line_word(SRC_BASE + wr_req.addr - DST_BASE))
		else begin
			$display("ERR write_data expected %h actual %h",
				line_word(SRC_BASE + $sampled(wr_req.addr) - DST_BASE), $sampled(wr_req.wdata));
			errors++;
		end

	// line index is the number of writes so far in this test
	a_wr_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wr_req.wvalid |-> wr_req.addr == DST_BASE + ADDR_W'(64 * (wr_cnt - wr0)))
		else begin
			$display("ERR write_addr expected %h actual %h",
				DST_BASE + ADDR_W'(64 * ($sampled(wr_cnt) - wr0)), $sampled(wr_req.addr));
			errors++;
		end

	a_ar_rdy: assert property (@(posedge clk_i) disable iff (!rst_ni) rd_req.arvalid |-> arready)
		else begin
			$display("read request raised while arready was low");
			errors++;
		end

	a_one_meta: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(rd_req.arvalid && is_meta(rd_req.addr)) |-> !meta_pend)
		else begin
			$display("second list or metadata read started before a response");
			errors++;
		end

	// tail moves only by a push-free, head only by a detach
	a_tail_upd: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(!$past(tbl_load) && list_tail != $past(list_tail)) |->
		(list_tail == WAY_B && freed_ways == $past(freed_ways) + 8'd1))
		else begin
			$display("ERR tail_update expected %h actual %h", WAY_B, $sampled(list_tail));
			errors++;
		end

	a_head_upd: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(!$past(tbl_load) && list_head != $past(list_head)) |-> list_head == WAY_B)
		else begin
			$display("ERR head_update expected %h actual %h", WAY_B, $sampled(list_head));
			errors++;
		end

	a_done_ends: assert property (@(posedge clk_i) disable iff (!rst_ni)
		compact_done |-> list_head == list_tail)
		else begin
			$display("compact_done pulsed while list head and tail differ");
			errors++;
		end

	a_err_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
		bus_error |=> bus_error && !rd_req.arvalid)
		else begin
			$display("bus_error dropped or a read followed it");
			errors++;
		end

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (exp == act) else begin
			$display("ERR %s expected %0h actual %0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic apply_reset();
		@(negedge clk_i);
		rst_ni = 1'b0;
		repeat (10) @(negedge clk_i);
		rst_ni = 1'b1;
	endtask

	task automatic load_list(input logic [WAY_W-1:0] h, input logic [WAY_W-1:0] t);
		@(negedge clk_i);
		tbl_load  = 1'b1;
		load_head = h;
		load_tail = t;
		@(negedge clk_i);
		tbl_load = 1'b0;
	endtask

	task automatic pulse_trig();
		@(negedge clk_i);
		compact_trig = 1'b1;
		@(negedge clk_i);
		compact_trig = 1'b0;
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (!compact_done && n < LIMIT) begin
			@(negedge clk_i);
			n++;
		end
		if (!compact_done) begin
			$display("timeout waiting for compact_done");
			errors++;
		end
	endtask

	task automatic wait_bus_error();
		int n;
		n = 0;
		while (!bus_error && n < LIMIT) begin
			@(negedge clk_i);
			n++;
		end
		if (!bus_error) begin
			$display("timeout waiting for bus_error");
			errors++;
		end
	endtask

	task automatic report(input string name);
		tests++;
		$display("test %s finished with %0d errors", name, errors - start);
	endtask

	initial begin
		clk_i = 1'b0;
		rst_ni = 1'b0;
		compact_trig = 1'b0;
		tbl_load = 1'b0;
		load_head = '0;
		load_tail = '0;
		err_req = 1'b0;
		errors = 0;
		tests = 0;
		repeat (10) @(negedge clk_i);
		rst_ni = 1'b1;

		// head equals tail after reset, so the trigger is ignored
		start = errors;
		check("reset_outputs", 4'b0000,
			{rd_req.arvalid, wr_req.wvalid, compact_done, bus_error});
		rd0 = rd_cnt;
		pulse_trig();
		repeat (30) @(negedge clk_i);
		check("idle_reads", 0, rd_cnt - rd0);
		report("reset_idle");

		start = errors;
		load_list(WAY_A, WAY_C);
		rd0 = rd_cnt;
		wr0 = wr_cnt;
		done0 = done_cnt;
		pulse_trig();
		wait_done();
		repeat (20) @(negedge clk_i); // a second pulse would show here
		check("done_count", 1, done_cnt - done0);
		check("write_count", SIZE + 1, wr_cnt - wr0);
		check("freed_ways", 1, freed_ways);
		check("list_head", WAY_B, list_head);
		check("list_tail", WAY_B, list_tail);
		report("compaction");

		start = errors;
		apply_reset();
		load_list(WAY_A, WAY_C);
		err_req = 1'b1;
		pulse_trig();
		wait_bus_error();
		rd0 = rd_cnt;
		repeat (30) @(negedge clk_i);
		check("reads_after_error", 0, rd_cnt - rd0);
		check("bus_error_held", 1, bus_error);
		err_req = 1'b0;
		apply_reset();
		check("bus_error_reset", 0, bus_error);
		report("bus_error");

		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- tb_zsp_mem.sv
`timescale 1ns/1ps

module tb_zsp_mem import zsp_pkg::*; #(
	parameter logic [WAY_W-1:0] WAY_A = 20'h00010,
	parameter logic [WAY_W-1:0] WAY_B = 20'h00020,
	parameter logic [WAY_W-1:0] WAY_C = 20'h00030,
	parameter logic [3:0]       SIZE  = 4'd3
) (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  rd_req_t  rd_req,
	input  logic     err_req,
	output logic     arready,
	output logic     wready,
	output rd_resp_t rd_resp
);

	logic [ADDR_W-1:0] pend[$]; // accepted reads, answered in order
	logic [31:0]       rnd;
	int                delay;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// source line content, a function of the whole address
	function automatic logic [DATA_W-1:0] line_fill(input logic [ADDR_W-1:0] a);
		return {a * 32'h9e37_79b9, a ^ 32'hc3c3_3c3c};
	endfunction

	function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] a);
		zsp_word_u        w;
		logic [WAY_W-1:0] way;
		w = '0;
		if (a >= LIST_BASE) begin // list node region
			way = WAY_W'((a - LIST_BASE) >> 3);
			w.entry.way = way;
			w.entry.prev_way = (way == WAY_B) ? WAY_A : (way == WAY_C) ? WAY_B : '0;
			w.entry.next_way = (way == WAY_A) ? WAY_B : (way == WAY_B) ? WAY_C : '0;
		end else if (a[11:0] == 12'h000) begin // metadata line of a way
			way = a[31:12];
			w.md.page0  = PAGE_W'((way_addr(way) + 32'h400) >> 6);
			w.md.page1  = PAGE_W'((way_addr(way) + 32'h800) >> 6);
			w.md.pg_vld = (way == WAY_B) ? 2'b11 : 2'b01;
			w.md.size   = SIZE;
		end else begin
			w = line_fill(a);
		end
		return w;
	endfunction

	initial begin
		rnd     = 32'hf15f_0c5e;
		delay   = 0;
		arready = 1'b0;
		wready  = 1'b0;
		rd_resp = '0;
	end

	always @(posedge clk_i) begin
		if (rst_ni && rd_req.arvalid)
			pend.push_back(rd_req.addr);
	end

	always @(negedge clk_i) begin
		rnd     = xorshift(rnd);
		arready = rnd[1:0] != 2'b00; // random gaps
		wready  = rnd[3:2] != 2'b00;
		rd_resp = '0;
		if (!rst_ni) begin
			pend.delete();
			delay = 0;
		end else if (pend.size() != 0) begin
			if (delay == 0) begin
				rd_resp.rvalid = 1'b1;
				rd_resp.rresp  = err_req ? 2'b10 : 2'b00;
				rd_resp.rdata  = read_word(pend.pop_front());
				delay          = int'(rnd[6:4]) % 4;
			end else begin
				delay--;
			end
		end
	end

endmodule

//--- zsp_compact_top.sv
`timescale 1ns/1ps

module zsp_compact_top import zsp_pkg::*; #(
	parameter int FIFO_DEPTH = 16,
	parameter int CNT_W      = 8
) (
	input  logic             clk_i,
	input  logic             rst_ni,
	input  logic             compact_trig,
	input  logic             tbl_load,
	input  logic [WAY_W-1:0] load_head,
	input  logic [WAY_W-1:0] load_tail,
	output rd_req_t          rd_req,
	input  logic             arready,
	input  rd_resp_t         rd_resp,
	output wr_req_t          wr_req,
	input  logic             wready,
	output logic             compact_done,
	output logic             bus_error,
	output logic [WAY_W-1:0] list_head,
	output logic [WAY_W-1:0] list_tail,
	output logic [CNT_W-1:0] freed_ways
);

	logic              fifo_push, fifo_pop, fifo_flush, fifo_full, fifo_empty;
	logic [DATA_W-1:0] fifo_data;
	logic              migrated, tbl_upd, tbl_done;
	mig_cmd_t          mig_cmd;
	tbl_upd_t          tbl_op;

	zsp_compacter u_compacter (
		.clk_i, .rst_ni, .compact_trig, .arready, .rd_resp, .fifo_full, .fifo_empty,
		.migrated, .tbl_done, .head(list_head), .tail(list_tail), .rd_req, .fifo_push,
		.fifo_flush, .mig_cmd, .tbl_upd, .tbl_op, .compact_done, .bus_error
	);

	zsp_line_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_line_fifo (
		.clk_i, .rst_ni, .flush(fifo_flush), .push(fifo_push), .push_data(rd_resp.rdata),
		.pop(fifo_pop), .pop_data(fifo_data), .full(fifo_full), .empty(fifo_empty)
	);

	zsp_migrator u_migrator (
		.clk_i, .rst_ni, .mig_cmd, .flush(fifo_flush), .fifo_empty, .fifo_data, .wready,
		.fifo_pop, .wr_req, .migrated
	);

	zsp_list_table #(.CNT_W(CNT_W)) u_list_table (
		.clk_i, .rst_ni, .load(tbl_load), .load_head, .load_tail, .upd(tbl_upd),
		.upd_pkt(tbl_op), .head(list_head), .tail(list_tail), .done(tbl_done), .freed_ways
	);

endmodule

//--- zsp_compacter.sv
`timescale 1ns/1ps

module zsp_compacter import zsp_pkg::*; (
	input  logic             clk_i,
	input  logic             rst_ni,
	input  logic             compact_trig,
	input  logic             arready,
	input  rd_resp_t         rd_resp,
	input  logic             fifo_full,
	input  logic             fifo_empty,
	input  logic             migrated,
	input  logic             tbl_done,
	input  logic [WAY_W-1:0] head,
	input  logic [WAY_W-1:0] tail,
	output rd_req_t          rd_req,
	output logic             fifo_push,
	output logic             fifo_flush,
	output mig_cmd_t         mig_cmd,
	output logic             tbl_upd,
	output tbl_upd_t         tbl_op,
	output logic             compact_done,
	output logic             bus_error
);

	typedef enum logic [4:0] {
		S_IDLE, S_PEEK_TAIL, S_TAIL_REQ, S_WAIT_TAIL, S_DEC_TAIL, S_SRC_REQ, S_WAIT_SRC,
		S_PEEK_HEAD, S_HEAD_REQ, S_WAIT_HEAD, S_DEC_HEAD, S_DST_REQ, S_WAIT_DST,
		S_FLUSH, S_BURST, S_MIGRATE, S_PUSH_FREE, S_DETACH, S_UPD_CHECK, S_DONE, S_ERROR
	} state_e;

	typedef struct packed {
		page_md_t          md;
		logic [PAGE_W-1:0] page;
	} slot_t;

	state_e            state;
	zsp_word_u         rd_word, word_q;
	list_entry_t       src_ent, dst_ent;
	page_md_t          src_md, dst_md;
	slot_t             src_sel, dst_sel;
	logic [PAGE_W-1:0] src_page, dst_page_q;
	logic [ADDR_W-1:0] line_addr;
	logic [4:0]        burst_left, lines_q;
	logic              migrate_q, rd_pend;
	logic              rd_ok, rd_err, single_req, src_empty, dst_full;

	// want=1 takes the lowest valid page, want=0 the lowest free slot
	function automatic slot_t take_slot(input page_md_t md, input logic want);
		slot_t s;
		s.md   = md;
		s.page = md.page0;
		if (md.pg_vld[0] == want) begin
			s.md.pg_vld[0] = ~want;
		end else if (md.pg_vld[1] == want) begin
			s.page         = md.page1;
			s.md.pg_vld[1] = ~want;
		end
		return s;
	endfunction

	assign rd_word    = rd_resp.rdata;
	assign rd_ok      = rd_resp.rvalid && (rd_resp.rresp == 2'b00);
	assign rd_err     = rd_resp.rvalid && (rd_resp.rresp != 2'b00);
	assign src_empty  = ~|src_md.pg_vld;
	assign dst_full   = &dst_md.pg_vld;
	assign src_sel    = take_slot(state == S_WAIT_SRC ? rd_word.md : src_md, 1'b1);
	assign dst_sel    = take_slot(state == S_WAIT_DST ? rd_word.md : dst_md, 1'b0);
	assign single_req = state inside {S_TAIL_REQ, S_SRC_REQ, S_HEAD_REQ, S_DST_REQ};

	assign rd_req.arvalid = arready && (single_req ||
		(state == S_BURST && burst_left != 5'd0 && !fifo_full));

	always_comb begin
		case (state)
			S_TAIL_REQ: rd_req.addr = list_addr(tail);
			S_HEAD_REQ: rd_req.addr = list_addr(head);
			S_SRC_REQ:  rd_req.addr = way_addr(src_ent.way); // metadata line
			S_DST_REQ:  rd_req.addr = way_addr(dst_ent.way);
			default:    rd_req.addr = line_addr;
		endcase
	end

	assign fifo_push    = rd_ok && (state == S_BURST || state == S_MIGRATE);
	assign fifo_flush   = state == S_FLUSH;
	assign compact_done = state == S_DONE;
	assign bus_error    = state == S_ERROR;
	assign mig_cmd      = '{migrate: migrate_q, dst_page: dst_page_q, lines: lines_q};

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state      <= S_IDLE;
			burst_left <= '0;
			migrate_q  <= 1'b0;
			tbl_upd    <= 1'b0;
		end else begin
			tbl_upd <= 1'b0;
			case (state)
				S_IDLE:      if (compact_trig && head != tail) state <= S_PEEK_TAIL;
				S_PEEK_TAIL: state <= src_empty ? S_TAIL_REQ : S_PEEK_HEAD;
				S_TAIL_REQ:  if (arready) state <= S_WAIT_TAIL;
				S_WAIT_TAIL: if (rd_err) state <= S_ERROR; else if (rd_ok) state <= S_DEC_TAIL;
				S_DEC_TAIL:  state <= S_SRC_REQ;
				S_SRC_REQ:   if (arready) state <= S_WAIT_SRC;
				S_WAIT_SRC:  if (rd_err) state <= S_ERROR; else if (rd_ok) state <= S_PEEK_HEAD;
				S_PEEK_HEAD: state <= dst_full ? S_HEAD_REQ : S_FLUSH;
				S_HEAD_REQ:  if (arready) state <= S_WAIT_HEAD;
				S_WAIT_HEAD: if (rd_err) state <= S_ERROR; else if (rd_ok) state <= S_DEC_HEAD;
				S_DEC_HEAD:  state <= S_DST_REQ;
				S_DST_REQ:   if (arready) state <= S_WAIT_DST;
				S_WAIT_DST:  if (rd_err) state <= S_ERROR; else if (rd_ok) state <= S_FLUSH;
				S_FLUSH: begin
					if (fifo_empty) begin // normally already drained
						burst_left <= {1'b0, src_md.size} + 5'd1;
						state      <= S_BURST;
					end
				end
				S_BURST: begin
					if (rd_err) begin
						state <= S_ERROR;
					end else if (burst_left == 5'd0) begin
						migrate_q <= 1'b1; // late beats still land in the FIFO
						state     <= S_MIGRATE;
					end else if (rd_req.arvalid) begin
						burst_left <= burst_left - 5'd1;
					end
				end
				S_MIGRATE: begin
					if (rd_err) begin
						state <= S_ERROR;
					end else if (migrated) begin
						migrate_q <= 1'b0;
						tbl_upd   <= src_empty || dst_full;
						if (src_empty)
							state <= S_PUSH_FREE;
						else if (dst_full)
							state <= S_DETACH;
						else
							state <= S_UPD_CHECK;
					end
				end
				S_PUSH_FREE: begin
					if (tbl_done) begin
						tbl_upd <= dst_full;
						state   <= dst_full ? S_DETACH : S_UPD_CHECK;
					end
				end
				S_DETACH:    if (tbl_done) state <= S_UPD_CHECK;
				S_UPD_CHECK: state <= (head == tail) ? S_DONE : S_PEEK_TAIL;
				S_DONE:      state <= S_IDLE;
				S_ERROR:     migrate_q <= 1'b0; // held until reset
				default:     state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (rd_resp.rvalid)
			word_q <= rd_resp.rdata;
		if (state == S_IDLE && compact_trig) begin
			src_md.pg_vld <= 2'b00; // forces both fetches
			dst_md.pg_vld <= 2'b11;
		end
		if ((state == S_PEEK_TAIL && !src_empty) || (state == S_WAIT_SRC && rd_ok)) begin
			src_md   <= src_sel.md;
			src_page <= src_sel.page;
		end
		if ((state == S_PEEK_HEAD && !dst_full) || (state == S_WAIT_DST && rd_ok)) begin
			dst_md     <= dst_sel.md;
			dst_page_q <= dst_sel.page;
		end
		if (state == S_DEC_TAIL)
			src_ent <= word_q.entry;
		if (state == S_DEC_HEAD)
			dst_ent <= word_q.entry;
		if (state == S_FLUSH) begin
			line_addr <= page_addr(src_page);
			lines_q   <= {1'b0, src_md.size};
		end else if (state == S_BURST && rd_req.arvalid) begin
			line_addr <= line_addr + ADDR_W'(64);
		end
		if (state == S_MIGRATE && migrated)
			tbl_op <= src_empty ? '{OP_PUSH_FREE, src_ent} : '{OP_DETACH_HEAD, dst_ent};
		else if (state == S_PUSH_FREE && tbl_done)
			tbl_op <= '{OP_DETACH_HEAD, dst_ent};
	end

	// list/metadata read in flight
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni)
			rd_pend <= 1'b0;
		else if (rd_req.arvalid && single_req)
			rd_pend <= 1'b1;
		else if (rd_resp.rvalid)
			rd_pend <= 1'b0;
	end

	a_one_list_rd: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(rd_req.arvalid && single_req) |-> !rd_pend);

endmodule

//--- zsp_line_fifo.sv
`timescale 1ns/1ps

module zsp_line_fifo import zsp_pkg::*; #(
	parameter int FIFO_DEPTH = 16 // power of two, pointers wrap freely
) (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic              flush,
	input  logic              push,
	input  logic [DATA_W-1:0] push_data,
	input  logic              pop,
	output logic [DATA_W-1:0] pop_data,
	output logic              full,
	output logic              empty
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	logic [DATA_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr, rd_ptr;
	logic [PTR_W:0]    count;
	logic              do_push, do_pop;

	assign full     = count == (PTR_W + 1)'(FIFO_DEPTH);
	assign empty    = count == '0;
	assign do_push  = push && !full;
	assign do_pop   = pop && !empty;
	assign pop_data = mem[rd_ptr]; // show-ahead

	always_ff @(posedge clk_i) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	a_no_ovf: assert property (@(posedge clk_i) disable iff (!rst_ni) push |-> !full);
	a_no_udf: assert property (@(posedge clk_i) disable iff (!rst_ni) pop |-> !empty);

endmodule

//--- zsp_list_table.sv
`timescale 1ns/1ps

module zsp_list_table import zsp_pkg::*; #(
	parameter int CNT_W = 8
) (
	input  logic             clk_i,
	input  logic             rst_ni,
	input  logic             load,
	input  logic [WAY_W-1:0] load_head,
	input  logic [WAY_W-1:0] load_tail,
	input  logic             upd,
	input  tbl_upd_t         upd_pkt,
	output logic [WAY_W-1:0] head,
	output logic [WAY_W-1:0] tail,
	output logic             done,
	output logic [CNT_W-1:0] freed_ways
);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			head       <= '0;
			tail       <= '0;
			done       <= 1'b0;
			freed_ways <= '0;
		end else begin
			done <= upd; // one cycle after the strobe
			if (load) begin
				head <= load_head;
				tail <= load_tail;
			end else if (upd) begin
				case (upd_pkt.op)
					OP_PUSH_FREE: begin
						// emptied tail goes back to the pool
						tail       <= upd_pkt.entry.prev_way;
						freed_ways <= freed_ways + 1'b1;
					end
					OP_DETACH_HEAD: head <= upd_pkt.entry.next_way; // full head leaves the list
					default: ;
				endcase
			end
		end
	end

	a_op_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
		upd |-> upd_pkt.op != OP_NONE);

endmodule

//--- zsp_migrator.sv
`timescale 1ns/1ps

module zsp_migrator import zsp_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  mig_cmd_t          mig_cmd,
	input  logic              flush,
	input  logic              fifo_empty,
	input  logic [DATA_W-1:0] fifo_data,
	input  logic              wready,
	output logic              fifo_pop,
	output wr_req_t           wr_req,
	output logic              migrated
);

	logic [4:0] line_idx; // lines written to the destination page
	logic       done_q;   // page finished, waiting for migrate to drop
	logic       busy;

	assign busy     = mig_cmd.migrate && !done_q;
	assign fifo_pop = busy && !fifo_empty && wready;

	assign wr_req.wvalid = fifo_pop;
	assign wr_req.addr   = page_addr(mig_cmd.dst_page) + ADDR_W'({line_idx, 6'b00_0000});
	assign wr_req.wdata  = fifo_data;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			line_idx <= '0;
			done_q   <= 1'b0;
			migrated <= 1'b0;
		end else begin
			migrated <= 1'b0;
			if (flush)
				line_idx <= '0;
			else if (fifo_pop)
				line_idx <= line_idx + 5'd1;
			if (fifo_pop && line_idx == mig_cmd.lines) begin
				migrated <= 1'b1; // last line just went out
				done_q   <= 1'b1;
			end else if (!mig_cmd.migrate) begin
				done_q <= 1'b0;
			end
		end
	end

endmodule

//--- zsp_pkg.sv
package zsp_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 64; // one beat is one memory line
	localparam int WAY_W  = 20;
	localparam int PAGE_W = 26; // line-aligned byte address >> 6

	// list nodes live in their own region, one 64-bit word per way
	localparam logic [ADDR_W-1:0] LIST_BASE = 32'h8000_0000;

	typedef struct packed {
		logic [WAY_W-1:0] way;
		logic [WAY_W-1:0] prev_way;
		logic [WAY_W-1:0] next_way;
		logic [3:0]       pad;
	} list_entry_t;

	// sits in the first line of each way
	typedef struct packed {
		logic [PAGE_W-1:0] page0;
		logic [PAGE_W-1:0] page1;
		logic [1:0]        pg_vld;
		logic [3:0]        size; // lines per page minus one
		logic [5:0]        pad;
	} page_md_t;

	typedef union packed {
		list_entry_t entry;
		page_md_t    md;
	} zsp_word_u;

	typedef struct packed {
		logic              arvalid;
		logic [ADDR_W-1:0] addr;
	} rd_req_t;

	typedef struct packed {
		logic              rvalid;
		logic [1:0]        rresp;
		logic [DATA_W-1:0] rdata;
	} rd_resp_t;

	typedef struct packed {
		logic              wvalid;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} wr_req_t;

	typedef enum logic [1:0] {
		OP_NONE,
		OP_PUSH_FREE,
		OP_DETACH_HEAD
	} tbl_op_e;

	typedef struct packed {
		tbl_op_e     op;
		list_entry_t entry;
	} tbl_upd_t;

	typedef struct packed {
		logic              migrate;
		logic [PAGE_W-1:0] dst_page;
		logic [4:0]        lines;
	} mig_cmd_t;

	function automatic logic [ADDR_W-1:0] way_addr(input logic [WAY_W-1:0] way);
		return {way, 12'h000};
	endfunction

	function automatic logic [ADDR_W-1:0] page_addr(input logic [PAGE_W-1:0] page);
		return {page, 6'b00_0000};
	endfunction

	function automatic logic [ADDR_W-1:0] list_addr(input logic [WAY_W-1:0] way);
		return LIST_BASE + ADDR_W'({way, 3'b000});
	endfunction

endpackage
